//--- flist.f
common/vga_pkg.sv
design/vga_timing.sv
background/draw_background.sv
cursor/cursor_ctl.sv
cursor/draw_cursor.sv
design/memory_vga_top.sv
dv/memory_vga_tb.sv

//--- Bender.yml
package:
  name: memory_vga

sources:
  - common/vga_pkg.sv
  - design/vga_timing.sv
  - background/draw_background.sv
  - cursor/cursor_ctl.sv
  - cursor/draw_cursor.sv
  - design/memory_vga_top.sv
  - target: test
    files:
      - dv/memory_vga_tb.sv

//--- dv/memory_vga_tb.sv
`timescale 1ns/1ps

module memory_vga_tb;
    import vga_pkg::*;

    // Front porch, sync and back porch are all PORCH long
    localparam int H_ACTIVE     = 64;
    localparam int V_ACTIVE     = 48;
    localparam int PORCH        = 4;
    localparam int CURSOR_SIZE  = 8;
    localparam int H_TOTAL      = H_ACTIVE + 3 * PORCH;
    localparam int V_TOTAL      = V_ACTIVE + 3 * PORCH;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_POS      = 6;
    localparam int X_MAX        = H_ACTIVE - CURSOR_SIZE;
    localparam int Y_MAX        = V_ACTIVE - CURSOR_SIZE;
    // Frame 0, one frame per new position, the last shown frame and one spare
    localparam int CYCLE_LIMIT  = RESET_CYCLES + (NUM_POS + 3) * FRAME_CYCLES + 500;

    typedef enum int {T_TIMING, T_BORDER, T_TITLE, T_HANDSHAKE, T_CURSOR, T_RESET} test_t;
    typedef enum int {CLS_BLANK, CLS_BORDER, CLS_SIGN, CLS_FILL, CLS_CURSOR} pixel_cls_t;

    logic        pclk;
    logic        rst;
    cursor_pos_t pos;
    logic        pos_valid;
    logic        pos_ready;
    vga_bus_t    vga_out;

    int          seed;
    int          cycle_cnt = 0;
    int          chk_cnt[6] = '{default: 0};
    int          err_cnt[6] = '{default: 0};
    int          settle = 0;
    int          oh = 0;
    int          ov = 0;
    int          ahead_h;
    int          ahead_v;
    logic        model_on = 1'b0;
    logic        after_rst = 1'b0;
    cursor_pos_t acc_pos = '0;
    int          exp_class;
    logic [11:0] exp_rgb;
    logic [3:0]  exp_flags;
    logic        exp_ready;

    memory_vga_top #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(PORCH), .H_SYNC(PORCH), .H_BACK(PORCH),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(PORCH), .V_SYNC(PORCH), .V_BACK(PORCH),
        .CURSOR_SIZE(CURSOR_SIZE)
    ) dut_i (
        .pclk(pclk), .rst(rst), .pos(pos), .pos_valid(pos_valid),
        .pos_ready(pos_ready), .vga_out(vga_out)
    );

    initial begin
        pclk = 1'b0;
        forever #4 pclk = ~pclk;
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic int pixel_class(int h, int v, cursor_pos_t cp);
        int tx;
        int ty;
        tx = h - title_x;
        ty = v - title_y;
        if (h >= H_ACTIVE || v >= V_ACTIVE) return CLS_BLANK;
        if (h >= int'(cp.xpos) && h < int'(cp.xpos) + CURSOR_SIZE &&
            v >= int'(cp.ypos) && v < int'(cp.ypos) + CURSOR_SIZE) return CLS_CURSOR;
        if (v == 0 || v == V_ACTIVE - 1 || h == 0 || h == H_ACTIVE - 1) return CLS_BORDER;
        if (tx >= 0 && tx < title_cols * title_cell && ty >= 0 && ty < title_rows * title_cell)
            if (title_bitmap[ty / title_cell][title_cols - 1 - tx / title_cell]) return CLS_SIGN;
        return CLS_FILL;
    endfunction

    function automatic logic [11:0] class_colour(int cls, int h, int v);
        case (cls)
            CLS_BLANK:  return col_black;
            CLS_CURSOR: return col_cursor;
            CLS_SIGN:   return col_sign;
            CLS_FILL:   return col_fill;
            default: begin
                // Top and bottom rows win at the corners
                if (v == 0) return col_top;
                if (v == V_ACTIVE - 1) return col_bottom;
                if (h == 0) return col_left;
                return col_right;
            end
        endcase
    endfunction

    // The timing stage runs two pixels ahead of vga_out
    always_comb begin
        ahead_h   = (oh + 2) % H_TOTAL;
        ahead_v   = (oh + 2 >= H_TOTAL) ? (ov + 1) % V_TOTAL : ov;
        exp_ready = model_on && ahead_v >= V_ACTIVE;
        exp_flags = {oh >= H_ACTIVE + PORCH && oh < H_ACTIVE + 2 * PORCH,
                     ov >= V_ACTIVE + PORCH && ov < V_ACTIVE + 2 * PORCH,
                     oh >= H_ACTIVE, ov >= V_ACTIVE};
        exp_class = pixel_class(oh, ov, acc_pos);
        exp_rgb   = class_colour(exp_class, oh, ov);
    end

    always @(posedge pclk) begin
        after_rst <= rst;
        if (after_rst) chk_cnt[T_RESET] <= chk_cnt[T_RESET] + 1;
        if (!rst) chk_cnt[T_HANDSHAKE] <= chk_cnt[T_HANDSHAKE] + 1;
        if (model_on) begin
            chk_cnt[T_TIMING] <= chk_cnt[T_TIMING] + 1;
            if (exp_class == CLS_CURSOR) begin
                chk_cnt[T_CURSOR] <= chk_cnt[T_CURSOR] + 1;
            end else if (exp_class == CLS_SIGN || exp_class == CLS_FILL) begin
                chk_cnt[T_TITLE] <= chk_cnt[T_TITLE] + 1;
            end else begin
                chk_cnt[T_BORDER] <= chk_cnt[T_BORDER] + 1;
            end
        end
        if (rst) begin
            settle   <= 2;
            model_on <= 1'b0;
            oh       <= 0;
            ov       <= 0;
            acc_pos  <= '0;
        end else if (settle != 0) begin
            settle   <= settle - 1;
            model_on <= (settle == 1);
        end else begin
            oh <= (oh == H_TOTAL - 1) ? 0 : oh + 1;
            if (oh == H_TOTAL - 1) ov <= (ov == V_TOTAL - 1) ? 0 : ov + 1;
            if (pos_valid && exp_ready) begin
                acc_pos.xpos <= (pos.xpos > X_MAX) ? 11'(X_MAX) : pos.xpos;
                acc_pos.ypos <= (pos.ypos > Y_MAX) ? 11'(Y_MAX) : pos.ypos;
            end
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic value_error(int t, string name, logic [63:0] got, logic [63:0] exp);
        err_cnt[t]++;
        $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    endtask

    task automatic plain_error(int t, string msg);
        err_cnt[t]++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    reset_chk: assert property (@(posedge pclk) after_rst |-> {vga_out, pos_ready} == '0)
        else value_error(T_RESET, "{vga_out, pos_ready}", $sampled({vga_out, pos_ready}), 0);
    hcount_chk: assert property (@(posedge pclk) model_on |-> vga_out.hcount == oh)
        else value_error(T_TIMING, "vga_out.hcount", $sampled(vga_out.hcount), $sampled(oh));
    vcount_chk: assert property (@(posedge pclk) model_on |-> vga_out.vcount == ov)
        else value_error(T_TIMING, "vga_out.vcount", $sampled(vga_out.vcount), $sampled(ov));
    flags_chk: assert property (@(posedge pclk) model_on |->
        {vga_out.hsync, vga_out.vsync, vga_out.hblnk, vga_out.vblnk} == exp_flags)
        else value_error(T_TIMING, "vga_out {hsync,vsync,hblnk,vblnk}",
            $sampled({vga_out.hsync, vga_out.vsync, vga_out.hblnk, vga_out.vblnk}),
            $sampled(exp_flags));
    border_chk: assert property (@(posedge pclk) model_on &&
        (exp_class == CLS_BLANK || exp_class == CLS_BORDER) |-> vga_out.rgb == exp_rgb)
        else value_error(T_BORDER, "vga_out.rgb", $sampled(vga_out.rgb), $sampled(exp_rgb));
    title_chk: assert property (@(posedge pclk) model_on &&
        (exp_class == CLS_SIGN || exp_class == CLS_FILL) |-> vga_out.rgb == exp_rgb)
        else value_error(T_TITLE, "vga_out.rgb", $sampled(vga_out.rgb), $sampled(exp_rgb));
    cursor_chk: assert property (@(posedge pclk) model_on &&
        exp_class == CLS_CURSOR |-> vga_out.rgb == exp_rgb)
        else value_error(T_CURSOR, "vga_out.rgb", $sampled(vga_out.rgb), $sampled(exp_rgb));
    ready_chk: assert property (@(posedge pclk) !rst |-> pos_ready == exp_ready)
        else value_error(T_HANDSHAKE, "pos_ready", $sampled(pos_ready), $sampled(exp_ready));
    // Every position in this bench is offered while a frame is drawn
    first_take_chk: assert property (@(posedge pclk)
        model_on && pos_valid && pos_ready |-> ahead_h == 0 && ahead_v == V_ACTIVE)
        else plain_error(T_HANDSHAKE, "position was not taken at the first blanking cycle");

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic wait_ready(logic level, int t);
        int n = 0;
        do begin
            @(posedge pclk);
            n++;
        end while (pos_ready !== level && n < FRAME_CYCLES);
        if (pos_ready !== level) plain_error(t, "pos_ready did not change within a frame");
    endtask

    task automatic send_pos(cursor_pos_t p, int t);
        int n = 0;
        pos       <= p;
        pos_valid <= 1'b1;
        do begin
            @(posedge pclk);
            n++;
        end while (!pos_ready && n < FRAME_CYCLES);
        if (!pos_ready) plain_error(t, "position transfer did not complete within a frame");
        pos_valid <= 1'b0;
    endtask

    task automatic finish_test(int t, string name);
        if (chk_cnt[t] == 0) plain_error(t, {name, " test never reached a check"});
        $display("test %-9s %s: %0d checks, %0d errors", name,
                 (err_cnt[t] == 0) ? "passed" : "failed", chk_cnt[t], err_cnt[t]);
    endtask

    initial begin
        cursor_pos_t p;
        int          total_err;
        int          failed;
        seed      = 32'h674c_95bb;
        rst       = 1'b1;
        pos       = '0;
        pos_valid = 1'b0;
        total_err = 0;
        failed    = 0;
        repeat (RESET_CYCLES) @(posedge pclk);
        rst <= 1'b0;
        repeat (3) @(posedge pclk);
        finish_test(T_RESET, "reset");
        // Offered a few lines into frame 0 and held until blanking
        repeat (4 * H_TOTAL) @(posedge pclk);
        p.xpos = 11'd20;
        p.ypos = 11'd30;
        send_pos(p, T_HANDSHAKE);
        for (int i = 0; i < NUM_POS; i++) begin
            wait_ready(1'b0, T_CURSOR);
            if (i == NUM_POS - 1) begin
                p.xpos = 11'(H_ACTIVE + 5);
                p.ypos = 11'(V_ACTIVE + 9);
            end else begin
                p.xpos = 11'({$random(seed)} % (H_ACTIVE + 16));
                p.ypos = 11'({$random(seed)} % (V_ACTIVE + 16));
            end
            send_pos(p, T_HANDSHAKE);
        end
        finish_test(T_HANDSHAKE, "handshake");
        // Last position stays up for one whole frame
        wait_ready(1'b0, T_CURSOR);
        wait_ready(1'b1, T_CURSOR);
        repeat (4) @(posedge pclk);
        finish_test(T_CURSOR, "cursor");
        finish_test(T_TIMING, "timing");
        finish_test(T_BORDER, "border");
        finish_test(T_TITLE, "title");
        for (int t = 0; t < 6; t++) begin
            total_err += err_cnt[t];
            if (err_cnt[t] != 0) failed++;
        end
        $display("Summary: 6 tests, %0d failed, %0d errors", failed, total_err);
        if (total_err == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    always @(posedge pclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("Timeout: run did not end within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

endmodule

//--- design/memory_vga_top.sv
`timescale 1ns/1ps

module memory_vga_top #(
    parameter int H_ACTIVE    = vga_pkg::h_active,
    parameter int H_FRONT     = vga_pkg::h_front,
    parameter int H_SYNC      = vga_pkg::h_sync,
    parameter int H_BACK      = vga_pkg::h_back,
    parameter int V_ACTIVE    = vga_pkg::v_active,
    parameter int V_FRONT     = vga_pkg::v_front,
    parameter int V_SYNC      = vga_pkg::v_sync,
    parameter int V_BACK      = vga_pkg::v_back,
    parameter int CURSOR_SIZE = 32
) (
    input  logic                 pclk,
    input  logic                 rst,
    input  vga_pkg::cursor_pos_t pos,
    input  logic                 pos_valid,
    output logic                 pos_ready,
    output vga_pkg::vga_bus_t    vga_out
);
    import vga_pkg::*;

    vga_bus_t    timing_bus;
    vga_bus_t    bg_bus;
    cursor_pos_t cur_pos;

    ////////////////////////////////////////
    // Pixel pipeline
    ////////////////////////////////////////

    vga_timing #(
        .H_ACTIVE(H_ACTIVE),
        .H_FRONT (H_FRONT),
        .H_SYNC  (H_SYNC),
        .H_BACK  (H_BACK),
        .V_ACTIVE(V_ACTIVE),
        .V_FRONT (V_FRONT),
        .V_SYNC  (V_SYNC),
        .V_BACK  (V_BACK)
    ) vga_timing_i (
        .pclk   (pclk),
        .rst    (rst),
        .vga_out(timing_bus)
    );

    draw_background #(
        .H_ACTIVE(H_ACTIVE),
        .V_ACTIVE(V_ACTIVE)
    ) draw_background_i (
        .pclk   (pclk),
        .rst    (rst),
        .vga_in (timing_bus),
        .vga_out(bg_bus)
    );

    // Position handshake sees blanking at the timing stage
    cursor_ctl #(
        .H_ACTIVE   (H_ACTIVE),
        .V_ACTIVE   (V_ACTIVE),
        .CURSOR_SIZE(CURSOR_SIZE)
    ) cursor_ctl_i (
        .pclk     (pclk),
        .rst      (rst),
        .vga_in   (timing_bus),
        .pos      (pos),
        .pos_valid(pos_valid),
        .pos_ready(pos_ready),
        .cur_pos  (cur_pos)
    );

    draw_cursor #(
        .CURSOR_SIZE(CURSOR_SIZE)
    ) draw_cursor_i (
        .pclk   (pclk),
        .rst    (rst),
        .vga_in (bg_bus),
        .cur_pos(cur_pos),
        .vga_out(vga_out)
    );

endmodule

//--- cursor/draw_cursor.sv
`timescale 1ns/1ps

module draw_cursor #(
    parameter int CURSOR_SIZE = 32
) (
    input  logic                 pclk,
    input  logic                 rst,
    input  vga_pkg::vga_bus_t    vga_in,
    input  vga_pkg::cursor_pos_t cur_pos,
    output vga_pkg::vga_bus_t    vga_out
);
    import vga_pkg::*;

    localparam logic [10:0] SIZE = 11'(CURSOR_SIZE);

    logic [10:0] x_end;
    logic [10:0] y_end;
    logic        in_x;
    logic        in_y;
    logic [11:0] rgb_nxt;

    ////////////////////////////////////////
    // Cursor square
    ////////////////////////////////////////

    // The clamp in cursor_ctl keeps these sums in range
    always_comb begin
        x_end = cur_pos.xpos + SIZE;
        y_end = cur_pos.ypos + SIZE;
        in_x  = (vga_in.hcount >= cur_pos.xpos) && (vga_in.hcount < x_end);
        in_y  = (vga_in.vcount >= cur_pos.ypos) && (vga_in.vcount < y_end);
    end

    // Paint over the background but never into blanking
    always_comb begin
        if (!vga_in.hblnk && !vga_in.vblnk && in_x && in_y) begin
            rgb_nxt = col_cursor;
        end else begin
            rgb_nxt = vga_in.rgb;
        end
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out     <= vga_in;
            vga_out.rgb <= rgb_nxt;
        end
    end

endmodule

//--- cursor/cursor_ctl.sv
`timescale 1ns/1ps

module cursor_ctl #(
    parameter int H_ACTIVE    = vga_pkg::h_active,
    parameter int V_ACTIVE    = vga_pkg::v_active,
    parameter int CURSOR_SIZE = 32
) (
    input  logic                 pclk,
    input  logic                 rst,
    input  vga_pkg::vga_bus_t    vga_in,
    input  vga_pkg::cursor_pos_t pos,
    input  logic                 pos_valid,
    output logic                 pos_ready,
    output vga_pkg::cursor_pos_t cur_pos
);
    import vga_pkg::*;

    // Largest corner that keeps the whole square on screen
    localparam logic [10:0] X_MAX = 11'(H_ACTIVE - CURSOR_SIZE);
    localparam logic [10:0] Y_MAX = 11'(V_ACTIVE - CURSOR_SIZE);

    cursor_pos_t pos_clamped;

    // New positions only while the frame is not drawn
    assign pos_ready = vga_in.vblnk;

    always_comb begin
        pos_clamped.xpos = (pos.xpos > X_MAX) ? X_MAX : pos.xpos;
        pos_clamped.ypos = (pos.ypos > Y_MAX) ? Y_MAX : pos.ypos;
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            cur_pos <= '0;
        end else if (pos_valid && pos_ready) begin
            cur_pos <= pos_clamped;
        end
    end

endmodule

//--- background/draw_background.sv
`timescale 1ns/1ps

module draw_background #(
    parameter int H_ACTIVE = vga_pkg::h_active,
    parameter int V_ACTIVE = vga_pkg::v_active
) (
    input  logic              pclk,
    input  logic              rst,
    input  vga_pkg::vga_bus_t vga_in,
    output vga_pkg::vga_bus_t vga_out
);
    import vga_pkg::*;

    localparam int CELL_SHIFT = $clog2(title_cell);
    localparam int COL_W      = $clog2(title_cols);
    localparam int ROW_W      = $clog2(title_rows);

    localparam logic [10:0] H_LAST   = 11'(H_ACTIVE - 1);
    localparam logic [10:0] V_LAST   = 11'(V_ACTIVE - 1);
    localparam logic [10:0] TITLE_X0 = 11'(title_x);
    localparam logic [10:0] TITLE_X1 = 11'(title_x + title_cols * title_cell);
    localparam logic [10:0] TITLE_Y0 = 11'(title_y);
    localparam logic [10:0] TITLE_Y1 = 11'(title_y + title_rows * title_cell);

    logic [10:0]      dx;
    logic [10:0]      dy;
    logic [COL_W-1:0] cell_col;
    logic [ROW_W-1:0] cell_row;
    logic             in_title;
    logic             sign_px;
    logic [11:0]      rgb_nxt;

    ////////////////////////////////////////
    // Title bitmap lookup
    ////////////////////////////////////////

    always_comb begin
        dx       = vga_in.hcount - TITLE_X0;
        dy       = vga_in.vcount - TITLE_Y0;
        // Cell size is a power of two
        cell_col = COL_W'(dx >> CELL_SHIFT);
        cell_row = ROW_W'(dy >> CELL_SHIFT);
        in_title = (vga_in.hcount >= TITLE_X0) && (vga_in.hcount < TITLE_X1) &&
                   (vga_in.vcount >= TITLE_Y0) && (vga_in.vcount < TITLE_Y1);
        sign_px  = in_title && title_bitmap[cell_row][COL_W'(title_cols - 1) - cell_col];
    end

    // Top and bottom rows win the corners
    always_comb begin
        if (vga_in.vblnk || vga_in.hblnk) begin
            rgb_nxt = col_black;
        end else if (vga_in.vcount == 11'd0) begin
            rgb_nxt = col_top;
        end else if (vga_in.vcount == V_LAST) begin
            rgb_nxt = col_bottom;
        end else if (vga_in.hcount == 11'd0) begin
            rgb_nxt = col_left;
        end else if (vga_in.hcount == H_LAST) begin
            rgb_nxt = col_right;
        end else if (sign_px) begin
            rgb_nxt = col_sign;
        end else begin
            rgb_nxt = col_fill;
        end
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out     <= vga_in;
            vga_out.rgb <= rgb_nxt;
        end
    end

endmodule

//--- design/vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
    parameter int H_ACTIVE = vga_pkg::h_active,
    parameter int H_FRONT  = vga_pkg::h_front,
    parameter int H_SYNC   = vga_pkg::h_sync,
    parameter int H_BACK   = vga_pkg::h_back,
    parameter int V_ACTIVE = vga_pkg::v_active,
    parameter int V_FRONT  = vga_pkg::v_front,
    parameter int V_SYNC   = vga_pkg::v_sync,
    parameter int V_BACK   = vga_pkg::v_back
) (
    input  logic              pclk,
    input  logic              rst,
    output vga_pkg::vga_bus_t vga_out
);
    import vga_pkg::*;

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam logic [10:0] H_LAST       = 11'(H_TOTAL - 1);
    localparam logic [10:0] H_BLANK      = 11'(H_ACTIVE);
    localparam logic [10:0] H_SYNC_START = 11'(H_ACTIVE + H_FRONT);
    localparam logic [10:0] H_SYNC_END   = 11'(H_ACTIVE + H_FRONT + H_SYNC);

    localparam logic [10:0] V_LAST       = 11'(V_TOTAL - 1);
    localparam logic [10:0] V_BLANK      = 11'(V_ACTIVE);
    localparam logic [10:0] V_SYNC_START = 11'(V_ACTIVE + V_FRONT);
    localparam logic [10:0] V_SYNC_END   = 11'(V_ACTIVE + V_FRONT + V_SYNC);

    logic [10:0] hcount_nxt;
    logic [10:0] vcount_nxt;
    vga_bus_t    bus_nxt;

    // Counters step one pixel per clock
    always_comb begin
        if (vga_out.hcount == H_LAST) begin
            hcount_nxt = '0;
            if (vga_out.vcount == V_LAST) begin
                vcount_nxt = '0;
            end else begin
                vcount_nxt = vga_out.vcount + 11'd1;
            end
        end else begin
            hcount_nxt = vga_out.hcount + 11'd1;
            vcount_nxt = vga_out.vcount;
        end
    end

    // Syncs and blanking decoded from the next position
    always_comb begin
        bus_nxt.hcount = hcount_nxt;
        bus_nxt.vcount = vcount_nxt;
        bus_nxt.hblnk  = (hcount_nxt >= H_BLANK);
        bus_nxt.vblnk  = (vcount_nxt >= V_BLANK);
        bus_nxt.hsync  = (hcount_nxt >= H_SYNC_START) && (hcount_nxt < H_SYNC_END);
        bus_nxt.vsync  = (vcount_nxt >= V_SYNC_START) && (vcount_nxt < V_SYNC_END);
        bus_nxt.rgb    = col_black;
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out <= bus_nxt;
        end
    end

endmodule

//--- common/vga_pkg.sv
package vga_pkg;

    ////////////////////////////////////////
    // Pixel bus and cursor position
    ////////////////////////////////////////

    typedef struct packed {
        logic [10:0] hcount;
        logic [10:0] vcount;
        logic        hsync;
        logic        vsync;
        logic        hblnk;
        logic        vblnk;
        logic [11:0] rgb;
    } vga_bus_t;

    typedef struct packed {
        logic [10:0] xpos;
        logic [10:0] ypos;
    } cursor_pos_t;

    // Colours with 4 bits per channel
    localparam logic [11:0] col_black  = 12'h0_0_0;
    localparam logic [11:0] col_top    = 12'hf_f_0;
    localparam logic [11:0] col_bottom = 12'hf_0_0;
    localparam logic [11:0] col_left   = 12'h0_f_0;
    localparam logic [11:0] col_right  = 12'h0_0_f;
    localparam logic [11:0] col_sign   = 12'hf_8_b;
    localparam logic [11:0] col_fill   = 12'h8_8_f;
    localparam logic [11:0] col_cursor = 12'hf_f_f;

    // Default 1024x768 timing
    localparam int h_active = 1024;
    localparam int h_front  = 24;
    localparam int h_sync   = 136;
    localparam int h_back   = 160;
    localparam int v_active = 768;
    localparam int v_front  = 3;
    localparam int v_sync   = 6;
    localparam int v_back   = 29;

    ////////////////////////////////////////
    // Title sign
    ////////////////////////////////////////

    localparam int title_cols = 32;
    localparam int title_rows = 16;
    localparam int title_x    = 8;
    localparam int title_y    = 8;
    localparam int title_cell = 1;

    // Row 0 is the top row, bit 31 the leftmost cell
    localparam logic [0:title_rows-1][title_cols-1:0] title_bitmap = {
        32'h0000_0000, 32'h7fff_fffe, 32'h0000_0000, 32'h0000_0000,
        32'h427e_423c, 32'h6640_6642, 32'h5a40_5a42, 32'h427c_4242,
        32'h4240_4242, 32'h4240_4242, 32'h4240_4242, 32'h427e_423c,
        32'h0000_0000, 32'h0000_0000, 32'h7fff_fffe, 32'h0000_0000
    };

endpackage
